/* hdl/Wb_defines.svh */
/*
 * Writeback cluster parameters
 * Lane count, datapath widths and credit depths
 */

`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

`define WB_LANES        2   // Parallel writeback lanes
`define WB_DATA_W       32
`define WB_REG_W        5
`define WB_IN_CREDITS   2   // Dispatcher input queue depth
`define WB_LANE_CREDITS 2   // Per-lane FIFO depth

`endif

/* hdl/WbPkg.sv */
/*
 * Writeback cluster types
 * Result select and load width encodings shared by the writeback logic
 */

package WbPkg;

    // Writeback result source
    typedef enum logic [1:0] {
        PC8  = 2'd0,  // Link address for JAL, JALR
        ALU  = 2'd1,
        OUTB = 2'd2,  // Moved operand
        DM   = 2'd3   // Loaded data after extension
    } WbSelType;

    // Load width and signedness
    typedef enum logic [2:0] {
        LW  = 3'd0,
        LH  = 3'd1,
        LHU = 3'd2,
        LB  = 3'd3,
        LBU = 3'd4
    } LoadType;

endpackage

/* hdl/WbDispatch.sv */
/*
 * Writeback dispatcher
 * Queues instructions from the memory stage under credit flow control and
 * hands them to the lanes in round-robin order
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module WbDispatch
    import WbPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  inValid,
    input  logic [`WB_DATA_W-1:0] inPc,
    input  logic [`WB_DATA_W-1:0] inAluOut,
    input  logic [`WB_DATA_W-1:0] inOutB,
    input  logic [`WB_DATA_W-1:0] inDmOut,
    input  WbSelType              inWbSel,
    input  LoadType               inLoadType,
    input  logic [`WB_REG_W-1:0]  inDst,
    input  logic                  inRegWr,
    input  logic [`WB_LANES-1:0]  laneCredit,
    output logic                  inCredit,
    output logic [`WB_LANES-1:0]  laneValid,
    output logic [`WB_DATA_W-1:0] laneAluOut,
    output logic [`WB_DATA_W-1:0] lanePc,
    output logic [`WB_DATA_W-1:0] laneOutB,
    output logic [`WB_DATA_W-1:0] laneDmOut,
    output WbSelType              laneWbSel,
    output LoadType               laneLoadType,
    output logic [`WB_REG_W-1:0]  laneDst,
    output logic                  laneRegWr
);
    localparam int QDepth    = `WB_IN_CREDITS;
    localparam int PtrW      = (QDepth > 1) ? $clog2(QDepth) : 1;
    localparam int CntW      = $clog2(QDepth + 1);
    localparam int Lanes     = `WB_LANES;
    localparam int LanePtrW  = (Lanes > 1) ? $clog2(Lanes) : 1;
    localparam int LaneCredW = $clog2(`WB_LANE_CREDITS + 1);

    logic [`WB_DATA_W-1:0] qPc     [QDepth];
    logic [`WB_DATA_W-1:0] qAluOut [QDepth];
    logic [`WB_DATA_W-1:0] qOutB   [QDepth];
    logic [`WB_DATA_W-1:0] qDmOut  [QDepth];
    WbSelType              qWbSel  [QDepth];
    LoadType               qLoadType [QDepth];
    logic [`WB_REG_W-1:0]  qDst    [QDepth];
    logic                  qRegWr  [QDepth];

    logic [PtrW-1:0]      wrPtr;
    logic [PtrW-1:0]      rdPtr;
    logic [CntW-1:0]      qCount;
    logic [LanePtrW-1:0]  rrPtr;       // Next lane in program order
    logic [LaneCredW-1:0] credCnt [Lanes];
    logic                 push;
    logic                 send;

    assign push     = inValid && !flush;
    assign send     = (qCount != '0) && (credCnt[rrPtr] != '0) && !flush;
    assign inCredit = send;            // One upstream credit per pop

    always_comb begin
        laneValid        = '0;
        laneValid[rrPtr] = send;
    end

    // Head of queue on the shared lane bus
    assign lanePc       = qPc[rdPtr];
    assign laneAluOut   = qAluOut[rdPtr];
    assign laneOutB     = qOutB[rdPtr];
    assign laneDmOut    = qDmOut[rdPtr];
    assign laneWbSel    = qWbSel[rdPtr];
    assign laneLoadType = qLoadType[rdPtr];
    assign laneDst      = qDst[rdPtr];
    assign laneRegWr    = qRegWr[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            qPc[wrPtr]       <= inPc;
            qAluOut[wrPtr]   <= inAluOut;
            qOutB[wrPtr]     <= inOutB;
            qDmOut[wrPtr]    <= inDmOut;
            qWbSel[wrPtr]    <= inWbSel;
            qLoadType[wrPtr] <= inLoadType;
            qDst[wrPtr]      <= inDst;
            qRegWr[wrPtr]    <= inRegWr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            qCount <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(QDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (send) begin
                rdPtr <= (rdPtr == PtrW'(QDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            qCount <= qCount + CntW'(push) - CntW'(send);
        end
    end

    // Lane credit counters and round-robin pointer
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rrPtr <= '0;
            for (int i = 0; i < Lanes; i++) begin
                credCnt[i] <= LaneCredW'(`WB_LANE_CREDITS);
            end
        end else begin
            if (send) begin
                rrPtr <= (rrPtr == LanePtrW'(Lanes - 1)) ? '0 : rrPtr + 1'b1;
            end
            for (int i = 0; i < Lanes; i++) begin
                if (laneValid[i] && !laneCredit[i]) begin
                    credCnt[i] <= credCnt[i] - 1'b1;
                end else if (!laneValid[i] && laneCredit[i]) begin
                    credCnt[i] <= credCnt[i] + 1'b1;
                end
            end
        end
    end

    // Upstream must hold a credit before sending
    inNoOverflow: assert property (@(posedge clk) disable iff (rst)
        inValid |-> qCount != CntW'(QDepth));

    for (genvar g = 0; g < Lanes; g++) begin : gCredChk
        sendWithCredit: assert property (@(posedge clk) disable iff (rst)
            laneValid[g] |-> credCnt[g] != '0);
    end

endmodule

/* hdl/WbLane.sv */
/*
 * Writeback lane
 * Credit-sized FIFO into the WB pipeline register, then load extension
 * and result select, held until commit takes the result
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module WbLane
    import WbPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  laneValid,
    input  logic [`WB_DATA_W-1:0] laneAluOut,
    input  logic [`WB_DATA_W-1:0] lanePc,
    input  logic [`WB_DATA_W-1:0] laneOutB,
    input  logic [`WB_DATA_W-1:0] laneDmOut,
    input  WbSelType              laneWbSel,
    input  LoadType               laneLoadType,
    input  logic [`WB_REG_W-1:0]  laneDst,
    input  logic                  laneRegWr,
    input  logic                  resTake,
    output logic                  laneCredit,
    output logic                  resValid,
    output logic [`WB_REG_W-1:0]  resDst,
    output logic [`WB_DATA_W-1:0] resData,
    output logic                  resRegWr,
    output logic [`WB_DATA_W-1:0] resPc
);
    localparam int Depth = `WB_LANE_CREDITS;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    logic [`WB_DATA_W-1:0] fPc     [Depth];
    logic [`WB_DATA_W-1:0] fAluOut [Depth];
    logic [`WB_DATA_W-1:0] fOutB   [Depth];
    logic [`WB_DATA_W-1:0] fDmOut  [Depth];
    WbSelType              fWbSel  [Depth];
    LoadType               fLoadType [Depth];
    logic [`WB_REG_W-1:0]  fDst    [Depth];
    logic                  fRegWr  [Depth];
    logic [PtrW-1:0]       wrPtr;
    logic [PtrW-1:0]       rdPtr;
    logic [CntW-1:0]       fCount;

    // WB pipeline register
    logic                  regValid;
    logic [`WB_DATA_W-1:0] regPc;
    logic [`WB_DATA_W-1:0] regAluOut;
    logic [`WB_DATA_W-1:0] regOutB;
    logic [`WB_DATA_W-1:0] regDmOut;
    WbSelType              regWbSel;
    LoadType               regLoadType;
    logic [`WB_REG_W-1:0]  regDst;
    logic                  regRegWr;

    logic                  push;
    logic                  move;
    logic [7:0]            loadByte;
    logic [15:0]           loadHalf;
    logic [`WB_DATA_W-1:0] loadExt;

    assign push       = laneValid && !flush;
    assign move       = (fCount != '0) && (!regValid || resTake) && !flush;
    assign laneCredit = move;          // Slot freed in the FIFO

    always_ff @(posedge clk) begin
        if (push) begin
            fPc[wrPtr]       <= lanePc;
            fAluOut[wrPtr]   <= laneAluOut;
            fOutB[wrPtr]     <= laneOutB;
            fDmOut[wrPtr]    <= laneDmOut;
            fWbSel[wrPtr]    <= laneWbSel;
            fLoadType[wrPtr] <= laneLoadType;
            fDst[wrPtr]      <= laneDst;
            fRegWr[wrPtr]    <= laneRegWr;
        end
        if (move) begin
            regPc       <= fPc[rdPtr];
            regAluOut   <= fAluOut[rdPtr];
            regOutB     <= fOutB[rdPtr];
            regDmOut    <= fDmOut[rdPtr];
            regWbSel    <= fWbSel[rdPtr];
            regLoadType <= fLoadType[rdPtr];
            regDst      <= fDst[rdPtr];
            regRegWr    <= fRegWr[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            fCount   <= '0;
            regValid <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (move) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            fCount <= fCount + CntW'(push) - CntW'(move);
            if (move) begin
                regValid <= 1'b1;
            end else if (resTake) begin
                regValid <= 1'b0;
            end
        end
    end

    // Byte lane from address bits 1:0, half from bit 1
    assign loadByte = regDmOut[{regAluOut[1:0], 3'b000} +: 8];
    assign loadHalf = regAluOut[1] ? regDmOut[31:16] : regDmOut[15:0];

    always_comb begin
        case (regLoadType)
            LB:      loadExt = {{(`WB_DATA_W - 8){loadByte[7]}}, loadByte};
            LBU:     loadExt = {{(`WB_DATA_W - 8){1'b0}}, loadByte};
            LH:      loadExt = {{(`WB_DATA_W - 16){loadHalf[15]}}, loadHalf};
            LHU:     loadExt = {{(`WB_DATA_W - 16){1'b0}}, loadHalf};
            default: loadExt = regDmOut;   // LW
        endcase
    end

    always_comb begin
        case (regWbSel)
            PC8:     resData = regPc + 'd8;  // Return address past delay slot
            ALU:     resData = regAluOut;
            OUTB:    resData = regOutB;
            default: resData = loadExt;
        endcase
    end

    assign resValid = regValid;
    assign resDst   = regDst;
    assign resRegWr = regRegWr;
    assign resPc    = regPc;

    // Dispatcher credits keep the FIFO from overflowing
    fifoNoOverflow: assert property (@(posedge clk) disable iff (rst)
        laneValid |-> fCount != CntW'(Depth));

endmodule

/* hdl/WbCommit.sv */
/*
 * Writeback commit
 * Drains lane results in program order and drives the register file write
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module WbCommit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  stall,     // Data cache stall holds writeback
    input  logic [`WB_LANES-1:0]  resValid,
    input  logic [`WB_REG_W-1:0]  resDst [`WB_LANES],
    input  logic [`WB_DATA_W-1:0] resData [`WB_LANES],
    input  logic [`WB_LANES-1:0]  resRegWr,
    input  logic [`WB_DATA_W-1:0] resPc [`WB_LANES],
    output logic [`WB_LANES-1:0]  resTake,
    output logic                  wbValid,
    output logic [`WB_REG_W-1:0]  wbDst,
    output logic [`WB_DATA_W-1:0] wbResult,
    output logic [`WB_DATA_W-1:0] wbPc,
    output logic                  rfWe,
    output logic [`WB_REG_W-1:0]  rfAddr,
    output logic [`WB_DATA_W-1:0] rfData
);
    localparam int Lanes = `WB_LANES;
    localparam int PtrW  = (Lanes > 1) ? $clog2(Lanes) : 1;

    logic [PtrW-1:0] rrPtr;   // Lane holding the oldest instruction
    logic            take;

    assign take = resValid[rrPtr] && !stall && !flush;

    always_comb begin
        resTake        = '0;
        resTake[rrPtr] = take;
    end

    assign wbValid  = take;
    assign wbDst    = resDst[rrPtr];
    assign wbResult = resData[rrPtr];
    assign wbPc     = resPc[rrPtr];

    // r0 writes dropped here
    assign rfWe   = take && resRegWr[rrPtr] && (resDst[rrPtr] != '0);
    assign rfAddr = resDst[rrPtr];
    assign rfData = resData[rrPtr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rrPtr <= '0;
        end else if (take) begin
            rrPtr <= (rrPtr == PtrW'(Lanes - 1)) ? '0 : rrPtr + 1'b1;
        end
    end

    takeOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(resTake));

endmodule

/* hdl/RegFile.sv */
/*
 * General purpose register file
 * One write port, one combinational read port, r0 reads zero
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module RegFile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rfWe,
    input  logic [`WB_REG_W-1:0]  rfAddr,
    input  logic [`WB_DATA_W-1:0] rfData,
    input  logic [`WB_REG_W-1:0]  rdAddr,
    output logic [`WB_DATA_W-1:0] rdData
);
    localparam int Regs = 2 ** `WB_REG_W;

    logic [`WB_DATA_W-1:0] regs [Regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWe && (rfAddr != '0)) begin
            regs[rfAddr] <= rfData;
        end
    end

    // Hard-wired zero
    assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr];

endmodule

/* hdl/WbCluster.sv */
/*
 * Writeback cluster top
 * Dispatcher, parallel writeback lanes, in-order commit and register file
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module WbCluster
    import WbPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  inValid,
    input  logic [`WB_DATA_W-1:0] inPc,
    input  logic [`WB_DATA_W-1:0] inAluOut,
    input  logic [`WB_DATA_W-1:0] inOutB,
    input  logic [`WB_DATA_W-1:0] inDmOut,
    input  WbSelType              inWbSel,
    input  LoadType               inLoadType,
    input  logic [`WB_REG_W-1:0]  inDst,
    input  logic                  inRegWr,
    input  logic [`WB_REG_W-1:0]  rdAddr,
    output logic                  inCredit,
    output logic                  wbValid,
    output logic [`WB_REG_W-1:0]  wbDst,
    output logic [`WB_DATA_W-1:0] wbResult,
    output logic [`WB_DATA_W-1:0] wbPc,
    output logic [`WB_DATA_W-1:0] rdData
);
    // Dispatcher to lanes
    logic [`WB_LANES-1:0]  laneValid;
    logic [`WB_LANES-1:0]  laneCredit;
    logic [`WB_DATA_W-1:0] laneAluOut;
    logic [`WB_DATA_W-1:0] lanePc;
    logic [`WB_DATA_W-1:0] laneOutB;
    logic [`WB_DATA_W-1:0] laneDmOut;
    WbSelType              laneWbSel;
    LoadType               laneLoadType;
    logic [`WB_REG_W-1:0]  laneDst;
    logic                  laneRegWr;

    // Lanes to commit
    logic [`WB_LANES-1:0]  resValid;
    logic [`WB_LANES-1:0]  resTake;
    logic [`WB_LANES-1:0]  resRegWr;
    logic [`WB_REG_W-1:0]  resDst  [`WB_LANES];
    logic [`WB_DATA_W-1:0] resData [`WB_LANES];
    logic [`WB_DATA_W-1:0] resPc   [`WB_LANES];

    logic                  rfWe;
    logic [`WB_REG_W-1:0]  rfAddr;
    logic [`WB_DATA_W-1:0] rfData;

    WbDispatch uDispatch (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .inValid      (inValid),
        .inPc         (inPc),
        .inAluOut     (inAluOut),
        .inOutB       (inOutB),
        .inDmOut      (inDmOut),
        .inWbSel      (inWbSel),
        .inLoadType   (inLoadType),
        .inDst        (inDst),
        .inRegWr      (inRegWr),
        .laneCredit   (laneCredit),
        .inCredit     (inCredit),
        .laneValid    (laneValid),
        .laneAluOut   (laneAluOut),
        .lanePc       (lanePc),
        .laneOutB     (laneOutB),
        .laneDmOut    (laneDmOut),
        .laneWbSel    (laneWbSel),
        .laneLoadType (laneLoadType),
        .laneDst      (laneDst),
        .laneRegWr    (laneRegWr)
    );

    for (genvar g = 0; g < `WB_LANES; g++) begin : gLane
        WbLane uLane (
            .clk          (clk),
            .rst          (rst),
            .flush        (flush),
            .laneValid    (laneValid[g]),
            .laneAluOut   (laneAluOut),
            .lanePc       (lanePc),
            .laneOutB     (laneOutB),
            .laneDmOut    (laneDmOut),
            .laneWbSel    (laneWbSel),
            .laneLoadType (laneLoadType),
            .laneDst      (laneDst),
            .laneRegWr    (laneRegWr),
            .resTake      (resTake[g]),
            .laneCredit   (laneCredit[g]),
            .resValid     (resValid[g]),
            .resDst       (resDst[g]),
            .resData      (resData[g]),
            .resRegWr     (resRegWr[g]),
            .resPc        (resPc[g])
        );
    end

    WbCommit uCommit (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .stall    (stall),
        .resValid (resValid),
        .resDst   (resDst),
        .resData  (resData),
        .resRegWr (resRegWr),
        .resPc    (resPc),
        .resTake  (resTake),
        .wbValid  (wbValid),
        .wbDst    (wbDst),
        .wbResult (wbResult),
        .wbPc     (wbPc),
        .rfWe     (rfWe),
        .rfAddr   (rfAddr),
        .rfData   (rfData)
    );

    RegFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rfWe   (rfWe),
        .rfAddr (rfAddr),
        .rfData (rfData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

/* tb/WbClusterTb.sv */
/*
 * Writeback cluster testbench
 * Credit-respecting random and directed stimulus against a ring model of
 * expected results, checked by concurrent assertions
 */

`timescale 1ns/1ps
`include "Wb_defines.svh"

module WbClusterTb
    import WbPkg::*;
();
    localparam int ModelDepth = 1024;
    localparam int MaxCycles  = 4000;  // Phases need roughly 1500 cycles
    localparam int Slots      = `WB_IN_CREDITS + `WB_LANES * (`WB_LANE_CREDITS + 1);

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  stall;
    logic                  inValid;
    logic [`WB_DATA_W-1:0] inPc;
    logic [`WB_DATA_W-1:0] inAluOut;
    logic [`WB_DATA_W-1:0] inOutB;
    logic [`WB_DATA_W-1:0] inDmOut;
    WbSelType              inWbSel;
    LoadType               inLoadType;
    logic [`WB_REG_W-1:0]  inDst;
    logic                  inRegWr;
    logic [`WB_REG_W-1:0]  rdAddr;
    logic                  inCredit;
    logic                  wbValid;
    logic [`WB_REG_W-1:0]  wbDst;
    logic [`WB_DATA_W-1:0] wbResult;
    logic [`WB_DATA_W-1:0] wbPc;
    logic [`WB_DATA_W-1:0] rdData;

    // Ring model of accepted instructions in program order
    logic [`WB_DATA_W-1:0] expPc  [ModelDepth];
    logic [`WB_REG_W-1:0]  expDst [ModelDepth];
    logic [`WB_DATA_W-1:0] expRes [ModelDepth];
    logic                  expWr  [ModelDepth];
    int                    issueCyc [ModelDepth];
    logic [9:0]            wrIdx;
    logic [9:0]            rdIdx;
    logic [9:0]            inFlight;
    logic [`WB_DATA_W-1:0] shadow [32];   // Expected register file contents
    logic [`WB_DATA_W-1:0] pcNext;
    int                    credits;
    int                    cycles = 0;
    string                 testName;

    WbCluster dut0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .inValid    (inValid),
        .inPc       (inPc),
        .inAluOut   (inAluOut),
        .inOutB     (inOutB),
        .inDmOut    (inDmOut),
        .inWbSel    (inWbSel),
        .inLoadType (inLoadType),
        .inDst      (inDst),
        .inRegWr    (inRegWr),
        .rdAddr     (rdAddr),
        .inCredit   (inCredit),
        .wbValid    (wbValid),
        .wbDst      (wbDst),
        .wbResult   (wbResult),
        .wbPc       (wbPc),
        .rdData     (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic failValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        failRun($sformatf("** Error [%s] %s: expected %h, actual %h", testName, what, exp, act));
    endtask

    // Writeback value from select, load width and byte offset
    function automatic logic [`WB_DATA_W-1:0] expectedResult(
        input WbSelType sel, input LoadType lt, input logic [31:0] pc,
        input logic [31:0] alu, input logic [31:0] outB, input logic [31:0] dm);
        logic [31:0] byteVal;
        logic [31:0] halfVal;
        logic [31:0] ext;
        byteVal = (dm >> (alu[1:0] * 8)) & 32'h0000_00FF;
        halfVal = (alu[1] ? (dm >> 16) : dm) & 32'h0000_FFFF;
        case (lt)
            LB:      ext = byteVal[7] ? (byteVal | 32'hFFFF_FF00) : byteVal;
            LBU:     ext = byteVal;
            LH:      ext = halfVal[15] ? (halfVal | 32'hFFFF_0000) : halfVal;
            LHU:     ext = halfVal;
            default: ext = dm;
        endcase
        if (sel == PC8) return pc + 32'd8;
        else if (sel == ALU) return alu;
        else if (sel == OUTB) return outB;
        return ext;
    endfunction

    assign inFlight = wrIdx - rdIdx;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            failRun("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Upstream credit count, restored by flush
    always @(posedge clk) begin
        if (rst || flush) begin
            credits <= `WB_IN_CREDITS;
        end else begin
            credits <= credits - int'(inValid) + int'(inCredit);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wrIdx <= '0;
        end else if (inValid && !flush) begin
            expPc[wrIdx]    <= inPc;
            expDst[wrIdx]   <= inDst;
            expWr[wrIdx]    <= inRegWr;
            expRes[wrIdx]   <= expectedResult(inWbSel, inLoadType, inPc, inAluOut, inOutB,
                                              inDmOut);
            issueCyc[wrIdx] <= cycles;
            wrIdx           <= wrIdx + 10'd1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rdIdx <= '0;
            for (int r = 0; r < 32; r++) begin
                shadow[r] <= '0;
            end
        end else if (flush) begin
            rdIdx <= wrIdx;  // Flushed entries never retire
        end else if (wbValid) begin
            if (expWr[rdIdx] && expDst[rdIdx] != '0) begin
                shadow[expDst[rdIdx]] <= expRes[rdIdx];
            end
            rdIdx <= rdIdx + 10'd1;
        end
    end

    resetQuiet: assert property (@(posedge clk) rst |=> !wbValid && !inCredit)
        else failRun("Outputs active right after reset");
    commitExpected: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> rdIdx != wrIdx)
        else failRun("A result retired with no instruction outstanding");
    orderPc: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbPc == expPc[rdIdx])
        else failValue("wbPc", $sampled(expPc[rdIdx]), $sampled(wbPc));
    orderDst: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbDst == expDst[rdIdx])
        else failValue("wbDst", 32'($sampled(expDst[rdIdx])), 32'($sampled(wbDst)));
    resultMatch: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbResult == expRes[rdIdx])
        else failValue("wbResult", $sampled(expRes[rdIdx]), $sampled(wbResult));
    minLatency: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> cycles - issueCyc[rdIdx] >= 3)
        else failRun("An instruction retired less than three cycles after issue");
    rfContents: assert property (@(posedge clk) disable iff (rst)
        rdData == shadow[rdAddr])
        else failValue("rdData", $sampled(shadow[rdAddr]), $sampled(rdData));
    stallQuiet: assert property (@(posedge clk) disable iff (rst) stall |-> !wbValid)
        else failRun("A result retired while stall was high");
    fullNoCredit: assert property (@(posedge clk) disable iff (rst)
        inFlight == 10'(Slots) |-> !inCredit)
        else failRun("A credit came back while every buffer slot was occupied");
    creditRange: assert property (@(posedge clk) disable iff (rst)
        credits >= 0 && credits <= `WB_IN_CREDITS)
        else failRun("Upstream credit count left its legal range");
    flushQuiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> !wbValid && !inCredit)
        else failRun("Activity seen in the cycle after a flush");

    // Returned credit this edge is ignored, which only delays a send
    function automatic bit canSend();
        return credits > int'(inValid);
    endfunction

    task automatic driveInstr(input logic [31:0] alu, input logic [31:0] outB,
                              input logic [31:0] dm, input WbSelType sel, input LoadType lt,
                              input logic [`WB_REG_W-1:0] dst, input logic wr);
        inValid    <= 1'b1;
        inPc       <= pcNext;
        inAluOut   <= alu;
        inOutB     <= outB;
        inDmOut    <= dm;
        inWbSel    <= sel;
        inLoadType <= lt;
        inDst      <= dst;
        inRegWr    <= wr;
        pcNext     = pcNext + 32'd4;
    endtask

    task automatic sendInstr(input logic [31:0] alu, input logic [31:0] outB,
                             input logic [31:0] dm, input WbSelType sel, input LoadType lt,
                             input logic [`WB_REG_W-1:0] dst, input logic wr);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (canSend()) begin
                driveInstr(alu, outB, dm, sel, lt, dst, wr);
                done = 1'b1;
            end else begin
                inValid <= 1'b0;
            end
        end
    endtask

    task automatic offerRandom(output bit sent);
        logic [31:0] rnd;
        rnd = $urandom();
        @(posedge clk);
        sent = canSend();
        if (sent) begin
            driveInstr($urandom(), $urandom(), $urandom(), WbSelType'(rnd[10:9]),
                       LoadType'(rnd[13:11] % 3'd5), rnd[`WB_REG_W-1:0], rnd[8]);
        end else begin
            inValid <= 1'b0;
        end
    endtask

    task automatic sendRandom();
        bit sent;
        sent = 1'b0;
        while (!sent) offerRandom(sent);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            inValid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(2);
        while (rdIdx != wrIdx) idle(1);
    endtask

    initial begin
        int seed;
        bit sent;
        seed       = $urandom(32'h4df4);
        rst        = 1'b1;
        flush      = 1'b0;
        stall      = 1'b0;
        inValid    = 1'b0;
        inPc       = '0;
        inAluOut   = '0;
        inOutB     = '0;
        inDmOut    = '0;
        inWbSel    = PC8;
        inLoadType = LW;
        inDst      = '0;
        inRegWr    = 1'b0;
        rdAddr     = '0;
        pcNext     = 32'h0040_0000;
        testName   = "reset";
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        testName = "select_order";
        for (int i = 0; i < 200; i++) sendRandom();
        drain();

        testName = "load_ext";   // Every width at every byte offset
        for (int p = 0; p < 2; p++) begin
            for (int t = 0; t < 5; t++) begin
                for (int off = 0; off < 4; off++) begin
                    sendInstr(($urandom() & 32'hFFFF_FFFC) | off, $urandom(),
                              p ? 32'h7A85_3CE1 : 32'h8F7E_C35A, DM, LoadType'(t),
                              5'(1 + off + 4 * t), 1'b1);
                end
            end
        end
        drain();

        testName = "regfile";
        for (int r = 0; r < 32; r++) sendInstr(32'hA500_0000 ^ $urandom(), 32'h0, 32'h0, ALU, LW,
                                               5'(r), 1'b1);
        for (int r = 1; r < 8; r++) sendInstr(32'hDEAD_0000 | r, 32'h0, 32'h0, ALU, LW,
                                              5'(r), 1'b0);   // Must not land
        drain();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rdAddr <= 5'(r);
        end
        idle(2);

        testName = "stall";
        @(posedge clk);
        stall <= 1'b1;
        for (int i = 0; i < 30; i++) offerRandom(sent);
        @(posedge clk);
        stall   <= 1'b0;
        inValid <= 1'b0;
        drain();

        testName = "flush";
        @(posedge clk);
        stall <= 1'b1;
        for (int i = 0; i < 6; i++) sendRandom();
        idle(2);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        for (int i = 0; i < 10; i++) sendRandom();
        drain();

        $display("All tests passed!");
        $finish;
    end

endmodule

/* WbCluster.f */
+incdir+hdl
hdl/WbPkg.sv
hdl/WbDispatch.sv
hdl/WbLane.sv
hdl/WbCommit.sv
hdl/RegFile.sv
hdl/WbCluster.sv
tb/WbClusterTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the writeback cluster testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing -Wno-fatal \
    --top-module WbClusterTb -Mdir obj_dir -f WbCluster.f \
    && obj_dir/VWbClusterTb > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

[ -f sim.log ] && cat sim.log

grep -q "All tests passed!" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
